// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= polar_alu_tb
FILELIST  ?= polar_alu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu_defines.svh
//--------------------------------------------------------------------------
// Width macros for the ALU datapath and the polar byte lanes
//--------------------------------------------------------------------------

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Integer data word
`define ALU_XLEN 64

// Polar SIMD lanes
`define ALU_LANE_W 8
`define ALU_LANES 8

// Shift amounts, full width and word form
`define ALU_SHAMT_W 6
`define ALU_SHAMT32_W 5

`endif

// File: alu_int_unit.sv
//--------------------------------------------------------------------------
// Integer unit: shared adder, logic operations, set-less-than and
// branch resolution
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_int_unit (
    input  polar_alu_pkg::alu_op_e op_i,
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    output polar_alu_pkg::xlen_t   result_o,
    output logic                   branch_res_o
);

    logic                 negate_b;
    logic [`ALU_XLEN:0]   operand_b_neg;
    logic [`ALU_XLEN:0]   adder_sum;
    polar_alu_pkg::xlen_t adder_result;
    polar_alu_pkg::xlen_t logic_b;
    logic                 zero_flag;
    logic                 signed_cmp;
    logic                 less;

    // --------------------------------------------------------------------
    // Adder
    // --------------------------------------------------------------------

    // Inverted b serves subtraction, equality and the negated logic ops
    always_comb begin
        case (op_i)
            polar_alu_pkg::SUB,  polar_alu_pkg::SUBW,
            polar_alu_pkg::EQ,   polar_alu_pkg::NE,
            polar_alu_pkg::ANDN, polar_alu_pkg::ORN,
            polar_alu_pkg::XNOR: negate_b = 1'b1;
            default:             negate_b = 1'b0;
        endcase
    end

    // Carry-in rides in bit 0, so a - b becomes a + ~b + 1
    assign operand_b_neg = {operand_b_i, 1'b0} ^ {(`ALU_XLEN + 1){negate_b}};
    assign adder_sum     = {operand_a_i, 1'b1} + operand_b_neg;
    assign adder_result  = adder_sum[`ALU_XLEN:1];
    assign zero_flag     = ~|adder_result;

    assign logic_b = operand_b_neg[`ALU_XLEN:1];

    // --------------------------------------------------------------------
    // Comparison
    // --------------------------------------------------------------------

    assign signed_cmp = (op_i == polar_alu_pkg::SLTS) ||
                        (op_i == polar_alu_pkg::LTS)  ||
                        (op_i == polar_alu_pkg::GES);

    // One extra bit turns the unsigned compare into a signed one
    assign less = $signed({signed_cmp & operand_a_i[`ALU_XLEN-1], operand_a_i}) <
                  $signed({signed_cmp & operand_b_i[`ALU_XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            polar_alu_pkg::EQ:  branch_res_o = zero_flag;
            polar_alu_pkg::NE:  branch_res_o = ~zero_flag;
            polar_alu_pkg::LTS,
            polar_alu_pkg::LTU: branch_res_o = less;
            polar_alu_pkg::GES,
            polar_alu_pkg::GEU: branch_res_o = ~less;
            default:            branch_res_o = 1'b1;
        endcase
    end

    // --------------------------------------------------------------------
    // Result select
    // --------------------------------------------------------------------

    always_comb begin
        case (op_i)
            polar_alu_pkg::ANDL,
            polar_alu_pkg::ANDN: result_o = operand_a_i & logic_b;
            polar_alu_pkg::ORL,
            polar_alu_pkg::ORN:  result_o = operand_a_i | logic_b;
            polar_alu_pkg::XORL,
            polar_alu_pkg::XNOR: result_o = operand_a_i ^ logic_b;
            polar_alu_pkg::ADD,
            polar_alu_pkg::SUB:  result_o = adder_result;
            // Word forms keep the low half, sign-extended
            polar_alu_pkg::ADDW,
            polar_alu_pkg::SUBW: result_o = {{(`ALU_XLEN - 32){adder_result[31]}},
                                             adder_result[31:0]};
            polar_alu_pkg::SLTS,
            polar_alu_pkg::SLTU: result_o = {{(`ALU_XLEN - 1){1'b0}}, less};
            default:             result_o = '0;
        endcase
    end

endmodule

// File: alu_shifter.sv
//--------------------------------------------------------------------------
// Barrel shifter for 64-bit and word shifts, left shifts done by
// reversing the operand around a right shifter
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_shifter (
    input  polar_alu_pkg::alu_op_e op_i,
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    output polar_alu_pkg::xlen_t   result_o
);

    localparam int WORD_W = 32;

    logic                      shift_left;
    logic                      shift_arith;
    logic [`ALU_SHAMT_W-1:0]   shamt;
    logic [`ALU_SHAMT32_W-1:0] shamt32;
    polar_alu_pkg::xlen_t      a_rev;
    logic [WORD_W-1:0]         a_rev32;
    polar_alu_pkg::xlen_t      shift_in;
    logic [WORD_W-1:0]         shift_in32;
    logic [`ALU_XLEN:0]        right64;
    logic [WORD_W:0]           right32;
    polar_alu_pkg::xlen_t      left64;
    logic [WORD_W-1:0]         left32;
    polar_alu_pkg::xlen_t      res64;
    logic [WORD_W-1:0]         res32;

    assign shift_left  = (op_i == polar_alu_pkg::SLL) || (op_i == polar_alu_pkg::SLLW);
    assign shift_arith = (op_i == polar_alu_pkg::SRA) || (op_i == polar_alu_pkg::SRAW);

    assign shamt   = operand_b_i[`ALU_SHAMT_W-1:0];
    assign shamt32 = operand_b_i[`ALU_SHAMT32_W-1:0];

    // Bit reversal in and out of the right shifter
    for (genvar k = 0; k < `ALU_XLEN; k++) begin : g_rev64
        assign a_rev[k]  = operand_a_i[`ALU_XLEN-1-k];
        assign left64[k] = right64[`ALU_XLEN-1-k];
    end

    for (genvar k = 0; k < WORD_W; k++) begin : g_rev32
        assign a_rev32[k] = operand_a_i[WORD_W-1-k];
        assign left32[k]  = right32[WORD_W-1-k];
    end

    assign shift_in   = shift_left ? a_rev : operand_a_i;
    assign shift_in32 = shift_left ? a_rev32 : operand_a_i[WORD_W-1:0];

    // Extra top bit carries the sign only for arithmetic shifts
    assign right64 = $unsigned($signed({shift_arith & shift_in[`ALU_XLEN-1], shift_in}) >>> shamt);
    assign right32 = $unsigned($signed({shift_arith & shift_in32[WORD_W-1], shift_in32}) >>> shamt32);

    assign res64 = shift_left ? left64 : right64[`ALU_XLEN-1:0];
    assign res32 = shift_left ? left32 : right32[WORD_W-1:0];

    always_comb begin
        case (op_i)
            polar_alu_pkg::SLL, polar_alu_pkg::SRL,
            polar_alu_pkg::SRA:  result_o = res64;
            polar_alu_pkg::SLLW, polar_alu_pkg::SRLW,
            polar_alu_pkg::SRAW: result_o = {{(`ALU_XLEN - WORD_W){res32[WORD_W-1]}}, res32};
            default:             result_o = '0;
        endcase
    end

endmodule

// File: polar_alu.f
+incdir+.
polar_alu_pkg.sv
alu_int_unit.sv
alu_shifter.sv
polar_simd_unit.sv
polar_alu.sv
polar_alu_chk.sv
polar_alu_tb.sv

// File: polar_alu.sv
//--------------------------------------------------------------------------
// Polar ALU top level: four-phase req/ack control, operand registers,
// result select and result register
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module polar_alu (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_i,
    input  polar_alu_pkg::alu_op_e op_i,
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    output logic                   ack_o,
    output polar_alu_pkg::xlen_t   result_o,
    output logic                   branch_res_o
);

    polar_alu_pkg::alu_state_e state_q;
    polar_alu_pkg::alu_op_e    op_q;
    polar_alu_pkg::xlen_t      operand_a_q;
    polar_alu_pkg::xlen_t      operand_b_q;
    polar_alu_pkg::xlen_t      int_result;
    polar_alu_pkg::xlen_t      shift_result;
    polar_alu_pkg::xlen_t      polar_result;
    polar_alu_pkg::xlen_t      sel_result;
    logic                      branch_res;
    logic                      ack_q;
    polar_alu_pkg::xlen_t      result_q;
    logic                      branch_q;

    // Operand capture on request
    always_ff @(posedge clk_i) begin
        if (state_q == polar_alu_pkg::IDLE && req_i) begin
            op_q        <= op_i;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
        end
    end

    // --------------------------------------------------------------------
    // Datapath units
    // --------------------------------------------------------------------

    alu_int_unit u_int (
        .op_i         (op_q),
        .operand_a_i  (operand_a_q),
        .operand_b_i  (operand_b_q),
        .result_o     (int_result),
        .branch_res_o (branch_res)
    );

    alu_shifter u_shift (
        .op_i        (op_q),
        .operand_a_i (operand_a_q),
        .operand_b_i (operand_b_q),
        .result_o    (shift_result)
    );

    polar_simd_unit u_polar (
        .op_i        (op_q),
        .operand_a_i (operand_a_q),
        .operand_b_i (operand_b_q),
        .result_o    (polar_result)
    );

    // Result source by opcode class
    always_comb begin
        case (op_q)
            polar_alu_pkg::SLL,  polar_alu_pkg::SRL,  polar_alu_pkg::SRA,
            polar_alu_pkg::SLLW, polar_alu_pkg::SRLW,
            polar_alu_pkg::SRAW:       sel_result = shift_result;
            polar_alu_pkg::PL_ADDSAT,  polar_alu_pkg::PL_SUBSAT,
            polar_alu_pkg::PL_F,       polar_alu_pkg::PL_R,
            polar_alu_pkg::PL_EVAL,    polar_alu_pkg::PL_VADDREP,
            polar_alu_pkg::PL_SPCXOR:  sel_result = polar_result;
            default:                   sel_result = int_result;
        endcase
    end

    // --------------------------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= polar_alu_pkg::IDLE;
            ack_q    <= 1'b0;
            result_q <= '0;
            branch_q <= 1'b0;
        end else begin
            case (state_q)
                polar_alu_pkg::IDLE: begin
                    if (req_i) begin
                        state_q <= polar_alu_pkg::CALC;
                    end
                end
                polar_alu_pkg::CALC: begin
                    result_q <= sel_result;
                    branch_q <= branch_res;
                    ack_q    <= 1'b1;
                    state_q  <= polar_alu_pkg::DONE;
                end
                polar_alu_pkg::DONE: begin
                    // Hold the result until the requester lets go
                    if (!req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= polar_alu_pkg::IDLE;
                    end
                end
                default: begin
                    ack_q   <= 1'b0;
                    state_q <= polar_alu_pkg::IDLE;
                end
            endcase
        end
    end

    assign ack_o        = ack_q;
    assign result_o     = result_q;
    assign branch_res_o = branch_q;

endmodule

// File: polar_alu_chk.sv
//--------------------------------------------------------------------------
// Handshake assertions for the polar ALU top level
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "alu_defines.svh"

module polar_alu_chk (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 req_i,
    input logic                 ack_o,
    input polar_alu_pkg::xlen_t result_o
);

    int fail_count = 0;

    a_ack_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_o)
        else begin
            fail_count++;
            $error("ack_o high in the cycle after reset");
        end

    // ack_o shows up one edge late, so look back at req_i
    a_ack_rise_on_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_o) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack_o rose without a request");
        end

    a_result_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (ack_o && $past(ack_o)) |-> $stable(result_o))
        else begin
            fail_count++;
            $error("result_o changed while ack_o was high");
        end

endmodule

// File: polar_alu_pkg.sv
//--------------------------------------------------------------------------
// Operation encoding, handshake states and data types of the polar ALU
//--------------------------------------------------------------------------

`include "alu_defines.svh"

package polar_alu_pkg;

    // Operation codes, integer ops first and polar ops last
    typedef enum logic [5:0] {
        ADD,
        SUB,
        ADDW,
        SUBW,
        ANDL,
        ORL,
        XORL,
        ANDN,
        ORN,
        XNOR,
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        SLTS,
        SLTU,
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        PL_ADDSAT,
        PL_SUBSAT,
        PL_F,
        PL_R,
        PL_EVAL,
        PL_VADDREP,
        PL_SPCXOR
    } alu_op_e;

    // Four-phase req/ack states
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } alu_state_e;

    typedef logic [`ALU_XLEN-1:0] xlen_t;
    typedef logic signed [`ALU_LANE_W-1:0] lane_t;

endpackage

// File: polar_alu_tb.sv
//--------------------------------------------------------------------------
// Testbench for the polar ALU: reads vectors from the tests file, runs
// four-phase transactions and checks the result and the branch bit
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "alu_defines.svh"

module polar_alu_tb;

    localparam int ACK_TIMEOUT = 50;
    localparam int LONG_HOLD   = 24;

    logic                   clk_i;
    logic                   reset_i;
    logic                   req_i;
    polar_alu_pkg::alu_op_e op_i;
    polar_alu_pkg::xlen_t   operand_a_i;
    polar_alu_pkg::xlen_t   operand_b_i;
    logic                   ack_o;
    polar_alu_pkg::xlen_t   result_o;
    logic                   branch_res_o;

    polar_alu u_dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .ack_o        (ack_o),
        .result_o     (result_o),
        .branch_res_o (branch_res_o)
    );

    bind polar_alu polar_alu_chk u_chk (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .ack_o    (ack_o),
        .result_o (result_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_result(input string name, input polar_alu_pkg::xlen_t expected,
                                input polar_alu_pkg::xlen_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run("Result mismatch");
        end
    endtask

    task automatic check_branch(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_run("Branch bit mismatch");
        end
    endtask

    // Counts falling edges until ack_o reaches the wanted level
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        while (cycles < ACK_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            if (ack_o === level) begin
                return;
            end
        end
        stop_run($sformatf("Timeout: ack_o did not reach %b within %0d cycles",
                           level, ACK_TIMEOUT));
    endtask

    // One full four-phase transaction, started on a falling edge
    task automatic run_transaction(input polar_alu_pkg::alu_op_e op,
                                   input polar_alu_pkg::xlen_t a,
                                   input polar_alu_pkg::xlen_t b,
                                   input polar_alu_pkg::xlen_t exp_result,
                                   input logic exp_branch);
        int cycles;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        req_i       = 1'b1;
        wait_for_ack(1'b1, cycles);
        if (cycles != 2) begin
            stop_run($sformatf("ack_o rose %0d edges after req_i instead of 2", cycles));
        end
        check_result("result_o", exp_result, result_o);
        check_branch("branch_res_o", exp_branch, branch_res_o);
        // Reductions also get a long hold of req_i
        if (op == polar_alu_pkg::PL_VADDREP || op == polar_alu_pkg::PL_SPCXOR) begin
            repeat (LONG_HOLD) begin
                @(negedge clk_i);
                if (ack_o !== 1'b1) begin
                    stop_run("ack_o dropped while req_i was still high");
                end
                check_result("result_o", exp_result, result_o);
            end
        end
        req_i = 1'b0;
        wait_for_ack(1'b0, cycles);
        if (cycles != 1) begin
            stop_run($sformatf("ack_o fell %0d edges after req_i dropped instead of 1", cycles));
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int                   fd;
        int                   fields;
        int                   n_vectors;
        string                line;
        logic [5:0]           op_raw;
        polar_alu_pkg::xlen_t a;
        polar_alu_pkg::xlen_t b;
        polar_alu_pkg::xlen_t exp_result;
        logic                 exp_branch;

        reset_i     = 1'b1;
        req_i       = 1'b0;
        op_i        = polar_alu_pkg::ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        n_vectors   = 0;

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        if (ack_o !== 1'b0) begin
            stop_run("ack_o is high after reset");
        end
        check_result("result_o", '0, result_o);

        fd = $fopen("polar_alu_tests.txt", "r");
        if (fd == 0) begin
            stop_run("Cannot open polar_alu_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h", op_raw, a, b, exp_result, exp_branch);
            if (fields != 5) begin
                stop_run($sformatf("Malformed line in tests file: %s", line));
            end
            run_transaction(polar_alu_pkg::alu_op_e'(op_raw), a, b, exp_result, exp_branch);
            n_vectors++;
        end
        $fclose(fd);

        if (u_dut.u_chk.fail_count != 0) begin
            $display("%0d handshake assertion failures", u_dut.u_chk.fail_count);
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Completed %0d transactions", n_vectors);
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: polar_alu_tests.txt
# Columns: opcode (hex enum value), operand a, operand b, expected result, branch bit
# Integer add and subtract, word forms
00 7fffffffffffffff 0000000000000001 8000000000000000 1
01 0000000000000000 0000000000000001 ffffffffffffffff 1
02 000000007fffffff 0000000000000001 ffffffff80000000 1
03 0000000100000000 0000000000000001 ffffffffffffffff 1
# Logic operations and negated forms
04 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 1
05 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 fff0fff0fff0fff0 1
06 1234567890abcdef ffffffff00000000 edcba98790abcdef 1
07 ffffffffffffffff 00000000ffffffff ffffffff00000000 1
08 0000000000000000 00000000ffffffff ffffffff00000000 1
09 1234567890abcdef 1234567890abcdef ffffffffffffffff 1
# Shifts, amounts 0, 31 and 63, upper bits of b ignored
0a 0000000000000001 000000000000003f 8000000000000000 1
0a 00000000000000ff 0000000000000104 0000000000000ff0 1
0b 8000000000000000 000000000000003f 0000000000000001 1
0c 8000000000000000 000000000000003f ffffffffffffffff 1
0c fffffffffffffff0 0000000000000002 fffffffffffffffc 1
0c 8000000000000001 0000000000000000 8000000000000001 1
0d 0000000000000001 000000000000001f ffffffff80000000 1
0e ffffffff80000000 000000000000001f 0000000000000001 1
0e 0000000080000000 0000000000000000 ffffffff80000000 1
0f 0000000080000000 000000000000001f ffffffffffffffff 1
0f 00000000f0000000 0000000000000004 ffffffffff000000 1
# Set-less-than and branches, both outcomes
10 ffffffffffffffff 0000000000000001 0000000000000001 1
11 ffffffffffffffff 0000000000000001 0000000000000000 1
12 0000000000000005 0000000000000005 0000000000000000 1
12 0000000000000005 0000000000000006 0000000000000000 0
13 0000000000000005 0000000000000006 0000000000000000 1
13 0000000000000005 0000000000000005 0000000000000000 0
14 ffffffffffffffff 0000000000000001 0000000000000000 1
14 0000000000000001 ffffffffffffffff 0000000000000000 0
15 ffffffffffffffff 0000000000000001 0000000000000000 0
15 0000000000000001 ffffffffffffffff 0000000000000000 1
16 ffffffffffffffff 0000000000000001 0000000000000000 0
16 0000000000000005 0000000000000005 0000000000000000 1
17 ffffffffffffffff 0000000000000001 0000000000000000 1
17 0000000000000000 0000000000000001 0000000000000000 0
# Polar lane operations
18 7f80649c01ff8000 01ff649c02ff8005 7f817f8103fe8105 1
19 7f80800005108100 ff01008003207f01 7f81817f02f081ff 1
1a 05fbfb058000107f fd03fd037f85f001 fdfd03038100f001 1
1b 8001ff7f80000180 0000000000000002 0100010001000001 1
1b 8001ff7f80000180 ffffffffffffff01 0000000000000000 1
1b 8001ff7f80000180 0000000000000100 0100010001000001 1
1c 0100ff0102810110 0000000000000000 ff0000ff0000ff00 1
# Byte reductions, held long by the testbench
1d 1000000000000000 ffffffffffffffff 10000000000007f8 1
1d ffffffffffffffff 0102030405060708 0000000000000023 1
1e abcdef0123456700 0102040810204080 abcdef01234567ff 1
1e 00000000000000ff 1111111111111111 00000000000000ff 1
1e 0000000000000000 0102030405060708 0000000000000008 1

// File: polar_simd_unit.sv
//--------------------------------------------------------------------------
// Polar decoding unit with the signed byte-lane operations and the
// byte reductions of operand b
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "alu_defines.svh"

module polar_simd_unit (
    input  polar_alu_pkg::alu_op_e op_i,
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    output polar_alu_pkg::xlen_t   result_o
);

    localparam int W     = `ALU_LANE_W;
    localparam int RED_W = `ALU_LANE_W + 3;

    polar_alu_pkg::xlen_t addsat_res;
    polar_alu_pkg::xlen_t subsat_res;
    polar_alu_pkg::xlen_t f_res;
    polar_alu_pkg::xlen_t r_res;
    polar_alu_pkg::xlen_t eval_res;
    logic                 b_low_one;
    logic [RED_W-1:0]     byte_sum;
    logic [W-1:0]         byte_xor;

    // Saturation is symmetric so -128 never comes out
    function automatic logic [W-1:0] sat_lane(input logic signed [W:0] value);
        if (value > 9'sd127) begin
            return 8'h7f;
        end else if (value < -9'sd127) begin
            return 8'h81;
        end
        return value[W-1:0];
    endfunction

    assign b_low_one = (operand_b_i[W-1:0] == 8'd1);

    // --------------------------------------------------------------------
    // Per-lane operations
    // --------------------------------------------------------------------

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        polar_alu_pkg::lane_t lane_a;
        polar_alu_pkg::lane_t lane_b;
        logic signed [W:0]    lane_sum;
        logic signed [W:0]    lane_diff;
        logic [W-1:0]         abs_a;
        logic [W-1:0]         abs_b;
        logic [W-1:0]         mag_min;

        assign lane_a = operand_a_i[i*W +: W];
        assign lane_b = operand_b_i[i*W +: W];

        // Nine bits hold any sum or difference of two lanes
        assign lane_sum  = $signed({lane_a[W-1], lane_a}) + $signed({lane_b[W-1], lane_b});
        assign lane_diff = $signed({lane_a[W-1], lane_a}) - $signed({lane_b[W-1], lane_b});

        assign addsat_res[i*W +: W] = sat_lane(lane_sum);
        assign subsat_res[i*W +: W] = sat_lane(lane_diff);

        // Min-sum check node
        assign abs_a   = lane_a[W-1] ? -lane_a : lane_a;
        assign abs_b   = lane_b[W-1] ? -lane_b : lane_b;
        assign mag_min = (abs_a > abs_b) ? abs_b : abs_a;
        assign f_res[i*W +: W] = (lane_a[W-1] ^ lane_b[W-1]) ? -mag_min : mag_min;

        // Hard decision that a frozen bit in b forces to zero
        assign r_res[i*W +: W] = b_low_one ? '0 : {{(W - 1){1'b0}}, lane_a[W-1]};

        assign eval_res[i*W +: W] = (lane_a == 8'sd1) ? 8'hff : 8'h00;
    end

    // --------------------------------------------------------------------
    // Byte reductions of operand b
    // --------------------------------------------------------------------

    always_comb begin
        byte_sum = '0;
        byte_xor = '0;
        for (int i = 0; i < `ALU_LANES; i++) begin
            byte_sum = byte_sum + {3'b000, operand_b_i[i*W +: W]};
            byte_xor = byte_xor ^ operand_b_i[i*W +: W];
        end
    end

    always_comb begin
        case (op_i)
            polar_alu_pkg::PL_ADDSAT:  result_o = addsat_res;
            polar_alu_pkg::PL_SUBSAT:  result_o = subsat_res;
            polar_alu_pkg::PL_F:       result_o = f_res;
            polar_alu_pkg::PL_R:       result_o = r_res;
            polar_alu_pkg::PL_EVAL:    result_o = eval_res;
            polar_alu_pkg::PL_VADDREP: result_o = operand_a_i +
                                                  {{(`ALU_XLEN - RED_W){1'b0}}, byte_sum};
            polar_alu_pkg::PL_SPCXOR:  result_o = operand_a_i ^
                                                  {{(`ALU_XLEN - W){1'b0}}, byte_xor};
            default:                   result_o = '0;
        endcase
    end

endmodule
